// File: hdl/spi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI register subsystem shared definitions
// register map, register bus structs and defaults
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package spi_pkg;

    // register map
    localparam logic [7:0] ADDRESS_CHIP_ID    = 8'hDB;
    localparam logic [7:0] ADDRESS_CAPTURE    = 8'h20;
    localparam logic [7:0] ADDRESS_STATUS     = 8'h21;
    localparam logic [7:0] ADDRESS_IMAGE_READ = 8'h22;

    // top level defaults
    localparam logic [7:0] DEFAULT_CHIP_ID = 8'h81;
    localparam int DEFAULT_IMAGE_ADDRESS_BITS = 6;

    // from the SPI target toward the register groups
    typedef struct packed {
        logic [7:0] address;
        logic       address_valid;
        logic [7:0] copi_data;
        logic       copi_valid;
    } spi_register_bus_t;

    // byte offered back by a register group
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } spi_reply_t;

endpackage

`default_nettype wire

// File: hdl/spi_peripheral.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI mode-0 target
// first byte is the register address, later bytes
// are write strobes and clock out the reply bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module spi_peripheral (
    input  logic                       clock_18MHz_oscillator,
    input  logic                       rst_n,
    input  logic                       spi_select,
    input  logic                       spi_clock,
    input  logic                       spi_data_in,
    input  spi_pkg::spi_reply_t        reply,
    output logic                       spi_data_out,
    output spi_pkg::spi_register_bus_t bus
);

    logic [1:0] select_sync;
    logic [2:0] clock_sync;
    logic [1:0] data_sync;
    logic       selected;
    logic       clock_rise;
    logic       clock_fall;
    logic [2:0] bit_count;
    logic [6:0] rx_shift;
    logic [7:0] rx_byte;
    logic [7:0] tx_shift;

    // two flop synchronizers, third clock stage for edge detect
    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            select_sync <= 2'b11;
            clock_sync  <= 3'b000;
            data_sync   <= 2'b00;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync  <= {clock_sync[1:0], spi_clock};
            data_sync   <= {data_sync[0], spi_data_in};
        end
    end

    assign selected   = ~select_sync[1];
    assign clock_rise = clock_sync[1] & ~clock_sync[2];
    assign clock_fall = ~clock_sync[1] & clock_sync[2];
    assign rx_byte    = {rx_shift, data_sync[1]};

    // receive side
    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            bit_count <= 3'd0;
            rx_shift  <= 7'd0;
            bus       <= '0;
        end else begin
            bus.copi_valid <= 1'b0;
            if (!selected) begin
                bit_count         <= 3'd0;
                bus.address_valid <= 1'b0;
            end else if (clock_rise) begin
                rx_shift  <= rx_byte[6:0];
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    // first byte of the transaction is the address
                    if (!bus.address_valid) begin
                        bus.address       <= rx_byte;
                        bus.address_valid <= 1'b1;
                    end else begin
                        bus.copi_data  <= rx_byte;
                        bus.copi_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // transmit side, MSB first, changes on falling SPI clock
    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= 8'h00;
        end else if (!selected) begin
            tx_shift <= 8'h00;
        end else if (clock_fall) begin
            // byte boundary after the address phase
            if (bit_count == 3'd0 && bus.address_valid) begin
                tx_shift <= reply.valid ? reply.data : 8'h00;
            end else begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assign spi_data_out = tx_shift[7];

endmodule

`default_nettype wire

// File: hdl/spi_subperipheral_selector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register group selector
// address decode into enables, reply byte mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module spi_subperipheral_selector (
    input  spi_pkg::spi_register_bus_t bus,
    input  spi_pkg::spi_reply_t        chip_id_reply,
    input  spi_pkg::spi_reply_t        camera_reply,
    output logic                       chip_id_enable,
    output logic                       camera_enable,
    output spi_pkg::spi_reply_t        reply
);

    import spi_pkg::*;

    logic chip_id_match;
    logic camera_match;

    // address groups
    assign chip_id_match = (bus.address == ADDRESS_CHIP_ID);
    assign camera_match  = bus.address inside {ADDRESS_CAPTURE,
                                               ADDRESS_STATUS,
                                               ADDRESS_IMAGE_READ};

    assign chip_id_enable = bus.address_valid & chip_id_match;
    assign camera_enable  = bus.address_valid & camera_match;

    // unmatched address gives an invalid reply
    always_comb begin
        if (chip_id_enable) begin
            reply = chip_id_reply;
        end else if (camera_enable) begin
            reply = camera_reply;
        end else begin
            reply = '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/spi_register_chip_id.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chip identifier register
// fixed read-only byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module spi_register_chip_id #(
    parameter logic [7:0] CHIP_ID = spi_pkg::DEFAULT_CHIP_ID
) (
    input  logic                clock_18MHz_oscillator,
    input  logic                rst_n,
    input  logic                enable,
    output spi_pkg::spi_reply_t reply
);

    // valid trails enable by one clock
    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            reply <= '0;
        end else begin
            reply.valid <= enable;
            reply.data  <= enable ? CHIP_ID : 8'h00;
        end
    end

endmodule

`default_nettype wire

// File: hdl/camera_peripheral.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Camera register group
// capture command, busy status and image read port
// with an auto-incrementing pointer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module camera_peripheral #(
    parameter int IMAGE_ADDRESS_BITS = spi_pkg::DEFAULT_IMAGE_ADDRESS_BITS
) (
    input  logic                          clock_18MHz_oscillator,
    input  logic                          rst_n,
    input  logic                          enable,
    input  spi_pkg::spi_register_bus_t    bus,
    input  logic                          capture_busy,
    input  logic [7:0]                    image_read_data,
    output spi_pkg::spi_reply_t           reply,
    output logic                          capture_start,
    output logic [IMAGE_ADDRESS_BITS-1:0] image_read_address
);

    import spi_pkg::*;

    logic capture_selected;
    logic status_selected;
    logic image_selected;
    logic capture_written;
    logic address_valid_d;
    logic reply_valid;

    assign capture_selected = enable && (bus.address == ADDRESS_CAPTURE);
    assign status_selected  = enable && (bus.address == ADDRESS_STATUS);
    assign image_selected   = enable && (bus.address == ADDRESS_IMAGE_READ);

    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            capture_written    <= 1'b0;
            capture_start      <= 1'b0;
            address_valid_d    <= 1'b0;
            reply_valid        <= 1'b0;
            image_read_address <= '0;
        end else begin
            address_valid_d <= bus.address_valid;
            reply_valid     <= status_selected | image_selected;
            capture_start   <= 1'b0;

            // one capture per transaction, dropped while busy
            if (!bus.address_valid) begin
                capture_written <= 1'b0;
            end else if (capture_selected && bus.copi_valid && !capture_written) begin
                capture_written <= 1'b1;
                capture_start   <= ~capture_busy;
            end

            // pointer restarts with every new address phase
            if (bus.address_valid && !address_valid_d) begin
                image_read_address <= '0;
            end else if (image_selected && bus.copi_valid) begin
                image_read_address <= image_read_address + 1'b1;
            end
        end
    end

    // RAM output is already registered
    always_comb begin
        reply.valid = reply_valid;
        if (status_selected) begin
            reply.data = {7'd0, capture_busy};
        end else if (image_selected) begin
            reply.data = image_read_data;
        end else begin
            reply.data = 8'h00;
        end
    end

endmodule

`default_nettype wire

// File: hdl/camera_test_pattern.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Image buffer with test-pattern writer
// each capture fills the buffer with a ramp offset
// by the frame number
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module camera_test_pattern #(
    parameter int IMAGE_ADDRESS_BITS = spi_pkg::DEFAULT_IMAGE_ADDRESS_BITS
) (
    input  logic                          clock_18MHz_oscillator,
    input  logic                          rst_n,
    input  logic                          capture_start,
    input  logic [IMAGE_ADDRESS_BITS-1:0] image_read_address,
    output logic                          capture_busy,
    output logic [7:0]                    image_read_data
);

    logic [7:0]                    image_ram [2**IMAGE_ADDRESS_BITS];
    logic [7:0]                    frame_counter;
    logic [IMAGE_ADDRESS_BITS-1:0] write_index;

    // writer control
    always_ff @(posedge clock_18MHz_oscillator or negedge rst_n) begin
        if (!rst_n) begin
            capture_busy  <= 1'b0;
            frame_counter <= 8'd0;
            write_index   <= '0;
        end else if (capture_busy) begin
            write_index <= write_index + 1'b1;
            if (&write_index) begin
                capture_busy <= 1'b0;
            end
        end else if (capture_start) begin
            capture_busy  <= 1'b1;
            frame_counter <= frame_counter + 8'd1;
            write_index   <= '0;
        end
    end

    // buffer, one write per clock and a registered read
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (capture_busy) begin
            image_ram[write_index] <= 8'(write_index) + frame_counter;
        end
        image_read_data <= image_ram[image_read_address];
    end

endmodule

`default_nettype wire

// File: hdl/top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Camera FPGA register access top level
// SPI target, group selector and register groups
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module top #(
    parameter logic [7:0] CHIP_ID            = spi_pkg::DEFAULT_CHIP_ID,
    parameter int         IMAGE_ADDRESS_BITS = spi_pkg::DEFAULT_IMAGE_ADDRESS_BITS
) (
    input  logic clock_18MHz_oscillator,
    input  logic rst_n,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_data_in,
    output logic spi_data_out
);

    import spi_pkg::*;

    spi_register_bus_t bus;
    spi_reply_t        reply;
    spi_reply_t        chip_id_reply;
    spi_reply_t        camera_reply;
    logic              chip_id_enable;
    logic              camera_enable;
    logic              capture_start;
    logic              capture_busy;
    logic [7:0]        image_read_data;

    logic [IMAGE_ADDRESS_BITS-1:0] image_read_address;

    spi_peripheral spi_peripheral (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .reply(reply),
        .spi_data_out(spi_data_out),
        .bus(bus)
    );

    spi_subperipheral_selector spi_subperipheral_selector (
        .bus(bus),
        .chip_id_reply(chip_id_reply),
        .camera_reply(camera_reply),
        .chip_id_enable(chip_id_enable),
        .camera_enable(camera_enable),
        .reply(reply)
    );

    spi_register_chip_id #(
        .CHIP_ID(CHIP_ID)
    ) spi_register_chip_id (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .enable(chip_id_enable),
        .reply(chip_id_reply)
    );

    camera_peripheral #(
        .IMAGE_ADDRESS_BITS(IMAGE_ADDRESS_BITS)
    ) camera_peripheral (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .enable(camera_enable),
        .bus(bus),
        .capture_busy(capture_busy),
        .image_read_data(image_read_data),
        .reply(camera_reply),
        .capture_start(capture_start),
        .image_read_address(image_read_address)
    );

    // stands in for the sensor path
    camera_test_pattern #(
        .IMAGE_ADDRESS_BITS(IMAGE_ADDRESS_BITS)
    ) camera_test_pattern (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .capture_start(capture_start),
        .image_read_address(image_read_address),
        .capture_busy(capture_busy),
        .image_read_data(image_read_data)
    );

endmodule

`default_nettype wire

// File: sim/top_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Camera register subsystem testbench
// SPI host transactions against chip id, capture,
// status and image read registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module top_tb;

    localparam logic [7:0] CHIP_ID_ADDRESS = 8'hDB;
    localparam logic [7:0] CAPTURE_ADDRESS = 8'h20;
    localparam logic [7:0] STATUS_ADDRESS  = 8'h21;
    localparam logic [7:0] IMAGE_ADDRESS   = 8'h22;
    localparam logic [7:0] UNUSED_ADDRESS  = 8'h55;
    localparam logic [7:0] EXPECTED_ID     = 8'h81;
    localparam int         IMAGE_BYTES     = 64;
    localparam int         STATUS_POLLS    = 200;

    logic clock_18MHz_oscillator;
    logic rst_n;
    logic spi_select;
    logic spi_clock;
    logic spi_data_in;
    logic spi_data_out;

    logic [7:0] tx_bytes [0:255];
    logic [7:0] rx_bytes [0:255];
    integer     seed;
    int         error_count;
    int         check_count;
    int         test_count;
    int         errors_before;

    top u_dut (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out)
    );

    always #5 clock_18MHz_oscillator = ~clock_18MHz_oscillator;

    task automatic wait_cycles(input int count);
        int n;
        for (n = 0; n < count; n++) begin
            @(posedge clock_18MHz_oscillator);
        end
    endtask

    // mode 0, 16 system clocks per bit, MISO sampled mid-cycle before the rising edge
    task automatic exchange_byte(input logic [7:0] tx, output logic [7:0] rx);
        int b;
        rx = 8'h00;
        for (b = 7; b >= 0; b--) begin
            spi_clock   <= 1'b0;
            spi_data_in <= tx[b];
            wait_cycles(7);
            @(negedge clock_18MHz_oscillator);
            rx = {rx[6:0], spi_data_out};
            @(posedge clock_18MHz_oscillator);
            spi_clock <= 1'b1;
            wait_cycles(8);
        end
        spi_clock <= 1'b0;
    endtask

    // select, address, count data bytes from tx_bytes into rx_bytes, deselect
    task automatic run_transaction(input logic [7:0] address, input int count);
        logic [7:0] received;
        int i;
        spi_select <= 1'b0;
        wait_cycles(8);
        exchange_byte(address, received);
        for (i = 0; i < count; i++) begin
            exchange_byte(tx_bytes[i], received);
            rx_bytes[i] = received;
        end
        wait_cycles(8);
        spi_select <= 1'b1;
        wait_cycles(16);
    endtask

    task automatic check_byte(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
        check_count++;
        assert (actual === expected)
        else begin
            error_count++;
            $display("Mismatch at %0t: %s read 0x%02h, expected 0x%02h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_status_value(input logic [7:0] actual);
        check_count++;
        assert (actual === 8'h00 || actual === 8'h01)
        else begin
            error_count++;
            $display("Mismatch at %0t: status read 0x%02h, expected 0x00 or 0x01",
                     $time, actual);
        end
    endtask

    // status polls until the capture reports idle
    task automatic wait_capture_idle();
        int polls;
        polls = 0;
        tx_bytes[0] = 8'h00;
        run_transaction(STATUS_ADDRESS, 1);
        check_status_value(rx_bytes[0]);
        while (rx_bytes[0] !== 8'h00 && polls < STATUS_POLLS) begin
            run_transaction(STATUS_ADDRESS, 1);
            check_status_value(rx_bytes[0]);
            polls++;
        end
        if (rx_bytes[0] !== 8'h00) begin
            error_count++;
            $display("Capture still busy after %0d status polls", STATUS_POLLS);
        end
    endtask

    task automatic read_image_and_check(input int count, input int offset, input string what);
        logic [7:0] expected;
        int i;
        for (i = 0; i < count; i++) begin
            tx_bytes[i] = 8'h00;
        end
        run_transaction(IMAGE_ADDRESS, count);
        for (i = 0; i < count; i++) begin
            expected = 8'(i + offset);
            check_byte(rx_bytes[i], expected, what);
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s: %s (%0d errors)", test_count, name,
                 (error_count == errors_before) ? "passed" : "failed",
                 error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin
        clock_18MHz_oscillator = 1'b0;
        rst_n                  = 1'b0;
        spi_select             = 1'b1;
        spi_clock              = 1'b0;
        spi_data_in            = 1'b0;
        seed                   = 32'ha460_d810;
        error_count            = 0;
        check_count            = 0;
        test_count             = 0;
        errors_before          = 0;

        wait_cycles(4);
        rst_n <= 1'b1;
        wait_cycles(4);

        check_byte({7'd0, spi_data_out}, 8'h00, "data out after reset");
        tx_bytes[0] = 8'h00;
        tx_bytes[1] = 8'h00;
        tx_bytes[2] = 8'h00;
        run_transaction(CHIP_ID_ADDRESS, 3);
        check_byte(rx_bytes[0], EXPECTED_ID, "chip id byte 0");
        check_byte(rx_bytes[1], EXPECTED_ID, "chip id byte 1");
        check_byte(rx_bytes[2], EXPECTED_ID, "chip id byte 2");
        report_test("chip id");

        run_transaction(UNUSED_ADDRESS, 2);
        check_byte(rx_bytes[0], 8'h00, "unassigned byte 0");
        check_byte(rx_bytes[1], 8'h00, "unassigned byte 1");
        report_test("unassigned address");

        tx_bytes[0] = 8'($random(seed));
        run_transaction(CAPTURE_ADDRESS, 1);
        wait_capture_idle();
        report_test("first capture");

        read_image_and_check(IMAGE_BYTES, 1, "frame 1 image");
        report_test("frame 1 read");

        // the first short read leaves the pointer mid-buffer
        read_image_and_check(10, 1, "pointer restart");
        read_image_and_check(10, 1, "pointer restart repeat");
        report_test("pointer restart");

        tx_bytes[0] = 8'($random(seed));
        run_transaction(CAPTURE_ADDRESS, 1);
        wait_capture_idle();
        read_image_and_check(IMAGE_BYTES, 2, "frame 2 image");
        report_test("second capture");

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/spi_pkg.sv
hdl/spi_peripheral.sv
hdl/spi_subperipheral_selector.sv
hdl/spi_register_chip_id.sv
hdl/camera_peripheral.sv
hdl/camera_test_pattern.sv
hdl/top.sv
sim/top_tb.sv

// File: Bender.yml
package:
  name: camera_spi_registers

sources:
  - files:
      - hdl/spi_pkg.sv
      - hdl/spi_peripheral.sv
      - hdl/spi_subperipheral_selector.sv
      - hdl/spi_register_chip_id.sv
      - hdl/camera_peripheral.sv
      - hdl/camera_test_pattern.sv
      - hdl/top.sv
  - target: simulation
    files:
      - sim/top_tb.sv
